// ==== Makefile ====
# Verilator build and run for the acquisition core testbench
VERILATOR ?= verilator
TOP       ?= tbDataAcqCore
FILELIST  ?= dataAcqCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dataAcqCore.f ====
dataAcqPkg.sv
edgeCountSensor.sv
slopeCountSensor.sv
sensorFrontEnd.sv
measurementSequencer.sv
referenceBank.sv
dataAcqCore.sv
dataAcqCore_chk.sv
tbDataAcqCore.sv

// ==== dataAcqCore.sv ====
////////////////////
// Acquisition core top; one measurement at a time
// CPU waits for doneLatched, then pulses statusClear
////////////////////
`timescale 1ns/100ps

module dataAcqCore (
  input  logic                         Clk,
  input  logic                         En,
  input  logic [31:0]                  cpuCommand,
  input  logic                         statusClear,
  input  dataAcqPkg::sensorReadings_t  sensorReadings,
  output logic [31:0]                  resultForCpu,
  output logic [2:0]                   statusBits
);

  logic [dataAcqPkg::TypeWidth-1:0]    sensorType;
  logic [dataAcqPkg::WindowWidth-1:0]  windowCycles;
  logic [dataAcqPkg::SlopeWidth-1:0]   numSlopes;
  logic [dataAcqPkg::TimeoutWidth-1:0] timeoutCycles;
  logic [dataAcqPkg::ModeWidth-1:0]    mode;
  logic [dataAcqPkg::CfgWidth-1:0]     refCfg;
  logic                                measStart, measDone, resultLoad;
  logic [dataAcqPkg::ValueWidth-1:0]   rawValue, resultValue;
  logic [dataAcqPkg::ErrWidth-1:0]     rawErr, resultErr, finalErr;

  measurementSequencer seqInst (
    .Clk, .En, .cpuCommand, .statusClear, .measDone, .rawValue, .rawErr, .finalErr,
    .sensorType, .windowCycles, .numSlopes, .timeoutCycles, .mode, .refCfg,
    .measStart, .resultLoad, .resultValue, .resultErr, .statusBits
  );

  sensorFrontEnd frontEndInst (
    .Clk, .En, .sensorType, .windowCycles, .numSlopes, .timeoutCycles,
    .measStart, .sensorReadings, .measDone, .rawValue, .rawErr
  );

  referenceBank refBankInst (
    .Clk, .En, .resultLoad, .sensorType, .mode, .refCfg, .resultValue, .resultErr,
    .resultForCpu, .finalErr
  );

endmodule

// ==== dataAcqCore_chk.sv ====
////////////////////
// Protocol assertions, bound into every dataAcqCore
// Idle is inferred from ports: not busy, not done,
// and not busy one cycle earlier (first Complete cycle)
////////////////////
`timescale 1ns/100ps

module dataAcqCore_chk (
  input logic        Clk,
  input logic        En,
  input logic [31:0] cpuCommand,
  input logic        statusClear,
  input logic [2:0]  statusBits
);

  logic busy, doneLatched;

  assign busy        = statusBits[2];
  assign doneLatched = statusBits[0];

  // Never both at once
  busyDoneExclusive: assert property (@(posedge Clk) disable iff (!En)
    !(busy && doneLatched))
    else $error("busy and doneLatched are high together");

  clearDropsDone: assert property (@(posedge Clk) disable iff (!En)
    statusClear |=> !doneLatched)
    else $error("doneLatched still high the cycle after statusClear");

  // Accept in Idle starts Busy on the next edge
  acceptRaisesBusy: assert property (@(posedge Clk) disable iff (!En)
    (!busy && !doneLatched && !$past(busy) && cpuCommand != '0) |=> busy)
    else $error("nonzero command in Idle did not raise busy");

endmodule

bind dataAcqCore dataAcqCore_chk chkInst (.Clk, .En, .cpuCommand, .statusClear, .statusBits);

// ==== dataAcqPkg.sv ====
////////////////////
// Shared widths, codes and the command word layout for the acquisition core
// Index field is decoded but ignored; references are kept per sensor type only
// Mode 11 is reserved and is answered as unsupported
////////////////////
package dataAcqPkg;

  localparam int ValueWidth   = 16;
  localparam int ErrWidth     = 3;
  localparam int TagWidth     = 3;
  localparam int TypeWidth    = 3;
  localparam int TimeoutWidth = 12;
  localparam int AnalogWidth  = 12;
  localparam int WindowScale  = 16;  // Busy cycles per numClkCycles step
  localparam int WindowWidth  = 8;   // Holds 15 x WindowScale
  localparam int SlopeWidth   = 6;
  localparam int ModeWidth    = 2;
  localparam int CfgWidth     = 4;
  localparam int NumTypes     = 8;

  // Error codes, result bits [15:13]
  localparam logic [ErrWidth-1:0] ErrOk          = 3'b001;
  localparam logic [ErrWidth-1:0] ErrRef1Missing = 3'b010;
  localparam logic [ErrWidth-1:0] ErrRef2Missing = 3'b011;
  localparam logic [ErrWidth-1:0] ErrBadConfig   = 3'b100;
  localparam logic [ErrWidth-1:0] ErrTimeout     = 3'b101;
  localparam logic [ErrWidth-1:0] ErrRefWritten  = 3'b110;
  localparam logic [ErrWidth-1:0] ErrUnsupported = 3'b111;

  // Reference tags, result bits [12:10]
  localparam logic [TagWidth-1:0] TagRaw   = 3'b000;
  localparam logic [TagWidth-1:0] TagRef1  = 3'b001;
  localparam logic [TagWidth-1:0] TagRef2  = 3'b010;
  localparam logic [TagWidth-1:0] TagError = 3'b111;

  localparam logic [ModeWidth-1:0] ModeRaw  = 2'b00;
  localparam logic [ModeWidth-1:0] ModeRef1 = 2'b01;
  localparam logic [ModeWidth-1:0] ModeRef2 = 2'b10;

  localparam logic [CfgWidth-1:0] CfgWriteRef1 = 4'b0010;
  localparam logic [CfgWidth-1:0] CfgWriteRef2 = 4'b0100;
  localparam logic [CfgWidth-1:0] CfgWriteBoth = 4'b0101;

  localparam logic [TypeWidth-1:0] TypeRosc = 3'd1;
  localparam logic [TypeWidth-1:0] TypeDc   = 3'd2;
  localparam logic [TypeWidth-1:0] TypeTddb = 3'd4;
  localparam logic [TypeWidth-1:0] TypeSilc = 3'd5;
  localparam logic [TypeWidth-1:0] TypeTemp = 3'd6;
  localparam logic [TypeWidth-1:0] TypeVolt = 3'd7;

  // Sequencer states
  localparam logic [1:0] StIdle     = 2'd0;
  localparam logic [1:0] StBusy     = 2'd1;
  localparam logic [1:0] StComplete = 2'd2;

  typedef logic [NumTypes-1:0][ValueWidth-1:0] sensorReadings_t;  // Indexed by type

  typedef struct packed {
    logic [1:0]  mode;
    logic [2:0]  sensorType;
    logic [2:0]  index;
    logic [3:0]  numClkCycles;
    logic [15:0] unused;
    logic [3:0]  refCfg;
  } windowView_t;  // ROSC and TDDB

  typedef struct packed {
    logic [1:0] mode;
    logic [2:0] sensorType;
    logic [2:0] index;
    logic [5:0] numSlopes;
    logic [1:0] unused;
    logic [7:0] timeoutHi;
    logic [3:0] timeoutLo;
    logic [3:0] refCfg;
  } slopeView_t;  // SILC

  typedef union packed {
    windowView_t windowView;
    slopeView_t  slopeView;
  } cmdWord_u;

endpackage

// ==== edgeCountSensor.sv ====
////////////////////
// Counts 0-to-1 steps of sensorBit over windowCycles samples
// First sample at start, done windowCycles cycles later
// Zero window ends at once with ErrBadConfig
////////////////////
`timescale 1ns/100ps

module edgeCountSensor (
  input  logic                               Clk,
  input  logic                               En,
  input  logic                               start,
  input  logic [dataAcqPkg::WindowWidth-1:0] windowCycles,
  input  logic                               sensorBit,
  output logic                               done,
  output logic [dataAcqPkg::ValueWidth-1:0]  count,
  output logic [dataAcqPkg::ErrWidth-1:0]    err
);

  logic                               running;
  logic                               prevBit;    // Last sample
  logic [dataAcqPkg::WindowWidth-1:0] sampleCnt;  // Samples taken so far

  always_ff @(posedge Clk or negedge En) begin
    if (!En) begin
      running   <= 1'b0;
      prevBit   <= 1'b0;
      sampleCnt <= '0;
      done      <= 1'b0;
      count     <= '0;
      err       <= dataAcqPkg::ErrOk;
    end else begin
      done <= 1'b0;  // Pulse
      if (start) begin
        running   <= (windowCycles > 1);
        done      <= (windowCycles <= 1);
        prevBit   <= sensorBit;
        sampleCnt <= 1;
        count     <= '0;
        err       <= (windowCycles == '0) ? dataAcqPkg::ErrBadConfig : dataAcqPkg::ErrOk;
      end else if (running) begin
        prevBit   <= sensorBit;
        sampleCnt <= sampleCnt + 1'b1;
        if (!prevBit && sensorBit) count <= count + 1'b1;  // Rising step
        if (sampleCnt + 1'b1 == windowCycles) begin        // Last sample
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== measurementSequencer.sv ====
////////////////////
// Idle/Busy/Complete control and command decode
// Nonzero command only taken in Idle, others dropped
// Decoded fields are held stable until the next accept
////////////////////
`timescale 1ns/100ps

module measurementSequencer (
  input  logic                                Clk,
  input  logic                                En,
  input  logic [31:0]                         cpuCommand,
  input  logic                                statusClear,
  input  logic                                measDone,
  input  logic [dataAcqPkg::ValueWidth-1:0]   rawValue,
  input  logic [dataAcqPkg::ErrWidth-1:0]     rawErr,
  input  logic [dataAcqPkg::ErrWidth-1:0]     finalErr,
  output logic [dataAcqPkg::TypeWidth-1:0]    sensorType,
  output logic [dataAcqPkg::WindowWidth-1:0]  windowCycles,
  output logic [dataAcqPkg::SlopeWidth-1:0]   numSlopes,
  output logic [dataAcqPkg::TimeoutWidth-1:0] timeoutCycles,
  output logic [dataAcqPkg::ModeWidth-1:0]    mode,
  output logic [dataAcqPkg::CfgWidth-1:0]     refCfg,
  output logic                                measStart,
  output logic                                resultLoad,
  output logic [dataAcqPkg::ValueWidth-1:0]   resultValue,
  output logic [dataAcqPkg::ErrWidth-1:0]     resultErr,
  output logic [2:0]                          statusBits
);

  dataAcqPkg::cmdWord_u cmdReg;  // Captured command
  logic [1:0] state, nextState;
  logic       accept, busy, errSticky, doneLatched;

  assign accept = (state == dataAcqPkg::StIdle) && (cpuCommand != '0);
  assign busy   = (state == dataAcqPkg::StBusy);
  assign statusBits = {busy, errSticky, doneLatched};

  // Common fields sit at the same bits in both views
  always_comb begin
    sensorType    = cmdReg.windowView.sensorType;
    mode          = cmdReg.windowView.mode;
    refCfg        = cmdReg.windowView.refCfg;
    windowCycles  = '0;
    numSlopes     = '0;
    timeoutCycles = '0;
    case (sensorType)
      dataAcqPkg::TypeRosc, dataAcqPkg::TypeTddb:
        windowCycles = dataAcqPkg::WindowWidth'(cmdReg.windowView.numClkCycles *
                                                dataAcqPkg::WindowScale);
      dataAcqPkg::TypeSilc: begin
        numSlopes     = cmdReg.slopeView.numSlopes;
        timeoutCycles = {cmdReg.slopeView.timeoutHi, cmdReg.slopeView.timeoutLo};
      end
      default: ;  // Analog and unsupported need no extra fields
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      dataAcqPkg::StIdle:     if (accept) nextState = dataAcqPkg::StBusy;
      dataAcqPkg::StBusy:     if (measDone) nextState = dataAcqPkg::StComplete;
      dataAcqPkg::StComplete: if (statusClear) nextState = dataAcqPkg::StIdle;
      default:                nextState = dataAcqPkg::StIdle;
    endcase
  end

  always_ff @(posedge Clk or negedge En) begin
    if (!En) begin
      state       <= dataAcqPkg::StIdle;
      cmdReg      <= '0;
      measStart   <= 1'b0;
      resultLoad  <= 1'b0;
      errSticky   <= 1'b0;
      doneLatched <= 1'b0;
    end else begin
      state      <= nextState;
      measStart  <= accept;           // First Busy cycle
      resultLoad <= busy && measDone;  // First Complete cycle
      if (accept) cmdReg <= cpuCommand;
      if (statusClear) begin  // Clear wins over a landing result
        errSticky   <= 1'b0;
        doneLatched <= 1'b0;
      end else if (resultLoad) begin
        doneLatched <= 1'b1;
        if (finalErr != dataAcqPkg::ErrOk && finalErr != dataAcqPkg::ErrRefWritten)
          errSticky <= 1'b1;
      end
    end
  end

  // Raw result held for the reference stage
  always_ff @(posedge Clk) begin
    if (busy && measDone) begin
      resultValue <= rawValue;
      resultErr   <= rawErr;
    end
  end

endmodule

// ==== referenceBank.sv ====
////////////////////
// REF1/REF2 per sensor type, subtraction and result packing
// Only raw mode writes references; first raw read fills REF1
// Differences wrap modulo 2^16
////////////////////
`timescale 1ns/100ps

module referenceBank (
  input  logic                              Clk,
  input  logic                              En,
  input  logic                              resultLoad,
  input  logic [dataAcqPkg::TypeWidth-1:0]  sensorType,
  input  logic [dataAcqPkg::ModeWidth-1:0]  mode,
  input  logic [dataAcqPkg::CfgWidth-1:0]   refCfg,
  input  logic [dataAcqPkg::ValueWidth-1:0] resultValue,
  input  logic [dataAcqPkg::ErrWidth-1:0]   resultErr,
  output logic [31:0]                       resultForCpu,
  output logic [dataAcqPkg::ErrWidth-1:0]   finalErr
);

  logic [dataAcqPkg::ValueWidth-1:0] ref1Mem [dataAcqPkg::NumTypes];
  logic [dataAcqPkg::ValueWidth-1:0] ref2Mem [dataAcqPkg::NumTypes];
  logic [dataAcqPkg::NumTypes-1:0]   ref1Valid, ref2Valid;
  logic                              wrRef1, wrRef2;
  logic [dataAcqPkg::ValueWidth-1:0] outValue;
  logic [dataAcqPkg::TagWidth-1:0]   outTag;

  always_comb begin
    wrRef1   = 1'b0;
    wrRef2   = 1'b0;
    outValue = '0;
    outTag   = dataAcqPkg::TagError;
    finalErr = resultErr;  // Sensor error passes through untouched
    if (resultErr == dataAcqPkg::ErrOk) begin
      case (mode)
        dataAcqPkg::ModeRaw: begin
          wrRef1 = !ref1Valid[sensorType] || refCfg == dataAcqPkg::CfgWriteRef1 ||
                   refCfg == dataAcqPkg::CfgWriteBoth;
          wrRef2 = refCfg == dataAcqPkg::CfgWriteRef2 || refCfg == dataAcqPkg::CfgWriteBoth;
          outValue = resultValue;
          outTag   = dataAcqPkg::TagRaw;
          if (wrRef1 || wrRef2) finalErr = dataAcqPkg::ErrRefWritten;
        end
        dataAcqPkg::ModeRef1:
          if (ref1Valid[sensorType]) begin
            outValue = resultValue - ref1Mem[sensorType];
            outTag   = dataAcqPkg::TagRef1;
          end else finalErr = dataAcqPkg::ErrRef1Missing;
        dataAcqPkg::ModeRef2:
          if (ref2Valid[sensorType]) begin
            outValue = resultValue - ref2Mem[sensorType];
            outTag   = dataAcqPkg::TagRef2;
          end else finalErr = dataAcqPkg::ErrRef2Missing;
        default: finalErr = dataAcqPkg::ErrUnsupported;  // Mode 11
      endcase
    end
  end

  always_ff @(posedge Clk) begin
    if (resultLoad && wrRef1) ref1Mem[sensorType] <= resultValue;
    if (resultLoad && wrRef2) ref2Mem[sensorType] <= resultValue;
  end

  always_ff @(posedge Clk or negedge En) begin
    if (!En) begin
      ref1Valid    <= '0;
      ref2Valid    <= '0;
      resultForCpu <= '0;
    end else if (resultLoad) begin
      if (wrRef1) ref1Valid[sensorType] <= 1'b1;
      if (wrRef2) ref2Valid[sensorType] <= 1'b1;
      resultForCpu <= {outValue, finalErr, outTag, 10'd0};  // Low bits reserved
    end
  end

endmodule

// ==== sensorFrontEnd.sv ====
////////////////////
// Routes measStart to one front end by type
// Types 2, 6, 7 take one reading; 0 and 3 unsupported
// sensorType must stay stable through Busy
////////////////////
`timescale 1ns/100ps

module sensorFrontEnd (
  input  logic                                Clk,
  input  logic                                En,
  input  logic [dataAcqPkg::TypeWidth-1:0]    sensorType,
  input  logic [dataAcqPkg::WindowWidth-1:0]  windowCycles,
  input  logic [dataAcqPkg::SlopeWidth-1:0]   numSlopes,
  input  logic [dataAcqPkg::TimeoutWidth-1:0] timeoutCycles,
  input  logic                                measStart,
  input  dataAcqPkg::sensorReadings_t         sensorReadings,
  output logic                                measDone,
  output logic [dataAcqPkg::ValueWidth-1:0]   rawValue,
  output logic [dataAcqPkg::ErrWidth-1:0]     rawErr
);

  logic roscStart, tddbStart, silcStart, anaStart, isAnalog;
  logic roscDone, tddbDone, silcDone, anaDone;
  logic [dataAcqPkg::ValueWidth-1:0] roscCount, tddbCount, silcElapsed, anaValue;
  logic [dataAcqPkg::ErrWidth-1:0]   roscErr, tddbErr, silcErr, anaErr;

  assign roscStart = measStart && (sensorType == dataAcqPkg::TypeRosc);
  assign tddbStart = measStart && (sensorType == dataAcqPkg::TypeTddb);
  assign silcStart = measStart && (sensorType == dataAcqPkg::TypeSilc);
  assign anaStart  = measStart && !(roscStart || tddbStart || silcStart);  // Incl. unsupported
  assign isAnalog  = (sensorType == dataAcqPkg::TypeDc) ||
                     (sensorType == dataAcqPkg::TypeTemp) ||
                     (sensorType == dataAcqPkg::TypeVolt);

  edgeCountSensor roscSensor (
    .Clk, .En, .start(roscStart), .windowCycles,
    .sensorBit(sensorReadings[dataAcqPkg::TypeRosc][0]),
    .done(roscDone), .count(roscCount), .err(roscErr)
  );

  edgeCountSensor tddbSensor (
    .Clk, .En, .start(tddbStart), .windowCycles,
    .sensorBit(sensorReadings[dataAcqPkg::TypeTddb][0]),
    .done(tddbDone), .count(tddbCount), .err(tddbErr)
  );

  slopeCountSensor silcSensor (
    .Clk, .En, .start(silcStart), .numSlopes, .timeoutCycles,
    .adcSample(sensorReadings[dataAcqPkg::TypeSilc][dataAcqPkg::AnalogWidth-1:0]),
    .done(silcDone), .elapsed(silcElapsed), .err(silcErr)
  );

  // Single-shot capture, done the cycle after start
  always_ff @(posedge Clk or negedge En) begin
    if (!En) begin
      anaDone  <= 1'b0;
      anaValue <= '0;
      anaErr   <= dataAcqPkg::ErrOk;
    end else begin
      anaDone <= anaStart;
      if (anaStart) begin
        anaValue <= isAnalog ?
          dataAcqPkg::ValueWidth'(sensorReadings[sensorType][dataAcqPkg::AnalogWidth-1:0]) : '0;
        anaErr   <= isAnalog ? dataAcqPkg::ErrOk : dataAcqPkg::ErrUnsupported;
      end
    end
  end

  always_comb begin
    case (sensorType)
      dataAcqPkg::TypeRosc: {measDone, rawValue, rawErr} = {roscDone, roscCount, roscErr};
      dataAcqPkg::TypeTddb: {measDone, rawValue, rawErr} = {tddbDone, tddbCount, tddbErr};
      dataAcqPkg::TypeSilc: {measDone, rawValue, rawErr} = {silcDone, silcElapsed, silcErr};
      default:              {measDone, rawValue, rawErr} = {anaDone, anaValue, anaErr};
    endcase
  end

endmodule

// ==== slopeCountSensor.sv ====
////////////////////
// Counts falling ADC steps until numSlopes or timeout
// Result is elapsed busy cycles, 0 on timeout
// numSlopes 0 gives ErrBadConfig, timeout 0 gives ErrTimeout
////////////////////
`timescale 1ns/100ps

module slopeCountSensor (
  input  logic                                Clk,
  input  logic                                En,
  input  logic                                start,
  input  logic [dataAcqPkg::SlopeWidth-1:0]   numSlopes,
  input  logic [dataAcqPkg::TimeoutWidth-1:0] timeoutCycles,
  input  logic [dataAcqPkg::AnalogWidth-1:0]  adcSample,
  output logic                                done,
  output logic [dataAcqPkg::ValueWidth-1:0]   elapsed,
  output logic [dataAcqPkg::ErrWidth-1:0]     err
);

  logic                                running, fallNow;
  logic [dataAcqPkg::AnalogWidth-1:0]  prevSample;
  logic [dataAcqPkg::SlopeWidth-1:0]   slopeCnt, slopeNext;
  logic [dataAcqPkg::TimeoutWidth-1:0] elapsedCnt, elapsedNext;

  assign fallNow     = adcSample < prevSample;
  assign slopeNext   = slopeCnt + dataAcqPkg::SlopeWidth'(fallNow);
  assign elapsedNext = elapsedCnt + 1'b1;

  always_ff @(posedge Clk or negedge En) begin
    if (!En) begin
      running    <= 1'b0;
      prevSample <= '0;
      slopeCnt   <= '0;
      elapsedCnt <= '0;
      done       <= 1'b0;
      elapsed    <= '0;
      err        <= dataAcqPkg::ErrOk;
    end else begin
      done <= 1'b0;
      if (start) begin
        prevSample <= adcSample;  // Reference sample
        slopeCnt   <= '0;
        elapsedCnt <= '0;
        elapsed    <= '0;
        running    <= (numSlopes != '0) && (timeoutCycles != '0);
        done       <= (numSlopes == '0) || (timeoutCycles == '0);
        if (numSlopes == '0)          err <= dataAcqPkg::ErrBadConfig;
        else if (timeoutCycles == '0) err <= dataAcqPkg::ErrTimeout;
        else                          err <= dataAcqPkg::ErrOk;
      end else if (running) begin
        prevSample <= adcSample;
        slopeCnt   <= slopeNext;
        elapsedCnt <= elapsedNext;
        if (slopeNext == numSlopes) begin  // Target beats timeout on the same cycle
          running <= 1'b0;
          done    <= 1'b1;
          elapsed <= dataAcqPkg::ValueWidth'(elapsedNext);
        end else if (elapsedNext == timeoutCycles) begin
          running <= 1'b0;
          done    <= 1'b1;
          err     <= dataAcqPkg::ErrTimeout;
        end
      end
    end
  end

endmodule

// ==== tbDataAcqCore.sv ====
////////////////////
// Random commands against a model with its own REF tables
// One command in flight; waits for doneLatched, then clears
// Readings change every cycle; model uses those seen during Busy
////////////////////
`timescale 1ns/100ps

module tbDataAcqCore;

  localparam int ClkPeriod = 100;
  localparam int NumTrans  = 200;
  localparam int WatchdogCycles = NumTrans * (dataAcqPkg::WindowScale * 15 + 4095 + 10) + 10;

  logic        Clk, En, statusClear;
  logic [31:0] cpuCommand, resultForCpu;
  logic [2:0]  statusBits;
  dataAcqPkg::sensorReadings_t sensorReadings;

  integer seed = 32'hed0b_f627;
  int errorCount = 0;
  int checkCount = 0;
  dataAcqPkg::sensorReadings_t busyQ[$];  // One entry per Busy cycle

  logic [dataAcqPkg::ValueWidth-1:0] ref1Tab [dataAcqPkg::NumTypes];  // Model REF1
  logic [dataAcqPkg::ValueWidth-1:0] ref2Tab [dataAcqPkg::NumTypes];  // Model REF2
  logic [dataAcqPkg::NumTypes-1:0]   ref1Ok, ref2Ok;

  dataAcqCore dataAcqCore_inst (
    .Clk, .En, .cpuCommand, .statusClear, .sensorReadings, .resultForCpu, .statusBits
  );

  initial begin
    Clk = 1'b0;
    forever #(ClkPeriod / 2) Clk = ~Clk;
  end

  // Fresh readings every cycle
  always @(posedge Clk) begin
    int r;
    for (int i = 0; i < dataAcqPkg::NumTypes; i++) begin
      r = $random(seed);
      sensorReadings[i] <= r[15:0];
    end
  end

  // Readings the DUT samples in this Busy cycle
  always @(negedge Clk)
    if (statusBits[2] === 1'b1) busyQ.push_back(sensorReadings);

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, DUT never finished", WatchdogCycles);
    $display("Done: errors found");
    $finish;
  end

  task automatic checkResult(input logic [dataAcqPkg::ValueWidth-1:0] expValue,
                             input logic [dataAcqPkg::ErrWidth-1:0]   expErr,
                             input logic [dataAcqPkg::TagWidth-1:0]   expTag);
    checkCount++;
    if (resultForCpu[31:16] !== expValue) begin
      errorCount++;
      $display("ERR %0t resultForCpu.value exp %h got %h", $time, expValue, resultForCpu[31:16]);
    end
    if (resultForCpu[15:13] !== expErr) begin
      errorCount++;
      $display("ERR %0t resultForCpu.err exp %b got %b", $time, expErr, resultForCpu[15:13]);
    end
    if (resultForCpu[12:10] !== expTag) begin
      errorCount++;
      $display("ERR %0t resultForCpu.tag exp %b got %b", $time, expTag, resultForCpu[12:10]);
    end
    if (resultForCpu[9:0] !== 10'd0) begin  // Reserved
      errorCount++;
      $display("ERR %0t resultForCpu.zero exp %h got %h", $time, 10'd0, resultForCpu[9:0]);
    end
  endtask

  task automatic checkStatus(input logic [2:0] expBits);
    checkCount++;
    if (statusBits !== expBits) begin
      errorCount++;
      $display("ERR %0t statusBits exp %b got %b", $time, expBits, statusBits);
    end
  endtask

  function automatic dataAcqPkg::cmdWord_u randomCommand();
    dataAcqPkg::cmdWord_u cmd;
    int r;
    r   = $random(seed);
    cmd = '0;
    cmd.windowView.mode       = (r[1:0] == 2'b11 && r[2]) ? 2'b00 : r[1:0];  // Mode 11 rare
    cmd.windowView.sensorType = r[5:3];
    cmd.windowView.index      = r[8:6];  // Ignored by DUT
    case (r[11:9])
      3'd0:    cmd.windowView.refCfg = dataAcqPkg::CfgWriteRef1;
      3'd1:    cmd.windowView.refCfg = dataAcqPkg::CfgWriteRef2;
      3'd2:    cmd.windowView.refCfg = dataAcqPkg::CfgWriteBoth;
      3'd3:    cmd.windowView.refCfg = r[15:12];
      default: cmd.windowView.refCfg = 4'd0;
    endcase
    if (r[5:3] == dataAcqPkg::TypeSilc) begin
      cmd.slopeView.numSlopes = {2'b00, r[19:16]};
      cmd.slopeView.timeoutHi = {7'd0, r[20]};  // Timeout 0..31
      cmd.slopeView.timeoutLo = r[27:24];
    end else begin
      cmd.windowView.numClkCycles = r[21] ? r[19:16] : {2'b00, r[17:16]};
    end
    if (cmd == '0) cmd.windowView.index = 3'd1;  // Zero is never accepted
    return cmd;
  endfunction

  // Raw sensor result and index of the last Busy sample it used
  task automatic modelSensor(input dataAcqPkg::cmdWord_u cmd,
                             output logic [dataAcqPkg::ValueWidth-1:0] val,
                             output logic [dataAcqPkg::ErrWidth-1:0] err, output int last);
    logic [2:0] sType;
    int win, target, timeout, slopes;
    sType = cmd.windowView.sensorType;
    val   = '0;
    err   = dataAcqPkg::ErrOk;
    last  = 0;
    if (sType == dataAcqPkg::TypeRosc || sType == dataAcqPkg::TypeTddb) begin
      win = int'(cmd.windowView.numClkCycles) * dataAcqPkg::WindowScale;
      if (win == 0) err = dataAcqPkg::ErrBadConfig;
      else begin
        last = win - 1;
        for (int i = 1; i < win && i < busyQ.size(); i++)
          if (!busyQ[i-1][sType][0] && busyQ[i][sType][0]) val++;  // Rising step
      end
    end else if (sType == dataAcqPkg::TypeSilc) begin
      target  = int'(cmd.slopeView.numSlopes);
      timeout = int'({cmd.slopeView.timeoutHi, cmd.slopeView.timeoutLo});
      slopes  = 0;
      if (target == 0) err = dataAcqPkg::ErrBadConfig;
      else if (timeout == 0) err = dataAcqPkg::ErrTimeout;
      else begin
        last = -1;  // No end found yet
        for (int i = 1; i < busyQ.size() && last < 0; i++) begin
          if (busyQ[i][sType][11:0] < busyQ[i-1][sType][11:0]) slopes++;
          if (slopes == target) begin
            val  = 16'(i);
            last = i;
          end else if (i == timeout) begin
            err  = dataAcqPkg::ErrTimeout;
            last = i;
          end
        end
      end
    end else if (sType == dataAcqPkg::TypeDc || sType == dataAcqPkg::TypeTemp ||
                 sType == dataAcqPkg::TypeVolt) begin
      val = {4'h0, busyQ[0][sType][11:0]};
    end else err = dataAcqPkg::ErrUnsupported;  // Types 0 and 3
  endtask

  // Applies the REF rules and updates the model tables
  task automatic modelRefs(input dataAcqPkg::cmdWord_u cmd,
                           input logic [15:0] raw, input logic [2:0] rawErr,
                           output logic [15:0] val, output logic [2:0] err,
                           output logic [2:0] tag);
    logic [2:0] sType;
    logic [3:0] cfg;
    logic       w1, w2;
    sType = cmd.windowView.sensorType;
    cfg   = cmd.windowView.refCfg;
    val   = '0;
    tag   = dataAcqPkg::TagError;
    err   = rawErr;
    if (rawErr == dataAcqPkg::ErrOk) begin
      case (cmd.windowView.mode)
        dataAcqPkg::ModeRaw: begin
          w1 = !ref1Ok[sType] || cfg == dataAcqPkg::CfgWriteRef1 || cfg == dataAcqPkg::CfgWriteBoth;
          w2 = cfg == dataAcqPkg::CfgWriteRef2 || cfg == dataAcqPkg::CfgWriteBoth;
          if (w1) begin
            ref1Tab[sType] = raw;
            ref1Ok[sType]  = 1'b1;
          end
          if (w2) begin
            ref2Tab[sType] = raw;
            ref2Ok[sType]  = 1'b1;
          end
          if (w1 || w2) err = dataAcqPkg::ErrRefWritten;
          val = raw;
          tag = dataAcqPkg::TagRaw;
        end
        dataAcqPkg::ModeRef1:
          if (ref1Ok[sType]) begin
            val = raw - ref1Tab[sType];  // Wraps
            tag = dataAcqPkg::TagRef1;
          end else err = dataAcqPkg::ErrRef1Missing;
        dataAcqPkg::ModeRef2:
          if (ref2Ok[sType]) begin
            val = raw - ref2Tab[sType];
            tag = dataAcqPkg::TagRef2;
          end else err = dataAcqPkg::ErrRef2Missing;
        default: err = dataAcqPkg::ErrUnsupported;
      endcase
    end
  endtask

  task automatic runTransaction();
    dataAcqPkg::cmdWord_u cmd;
    int last;
    logic [15:0] rawVal, expVal;
    logic [2:0]  rawErr, expErr, expTag;
    logic        expSticky;
    cmd = randomCommand();
    @(posedge Clk);
    cpuCommand <= cmd;
    busyQ.delete();
    @(posedge Clk);  // Accept edge
    cpuCommand <= '0;
    @(negedge Clk);
    checkStatus(3'b100);
    while (statusBits[0] !== 1'b1) @(negedge Clk);  // Result lands with doneLatched
    modelSensor(cmd, rawVal, rawErr, last);
    if (last < 0 || busyQ.size() != last + 2) begin
      errorCount++;
      $display("Busy lasted %0d cycles at %0t but the model expected %0d for command %h",
               busyQ.size(), $time, last + 2, cmd);
    end
    modelRefs(cmd, rawVal, rawErr, expVal, expErr, expTag);
    expSticky = (expErr != dataAcqPkg::ErrOk) && (expErr != dataAcqPkg::ErrRefWritten);
    checkResult(expVal, expErr, expTag);
    checkStatus({1'b0, expSticky, 1'b1});
    @(posedge Clk);
    statusClear <= 1'b1;
    @(posedge Clk);
    statusClear <= 1'b0;
    @(negedge Clk);
    checkStatus(3'b000);  // Both sticky bits gone
  endtask

  initial begin
    En             <= 1'b0;
    cpuCommand     <= '0;
    statusClear    <= 1'b0;
    sensorReadings <= '0;
    ref1Ok         = '0;
    ref2Ok         = '0;
    repeat (2) @(posedge Clk);
    @(negedge Clk);
    checkStatus(3'b000);
    checkResult(16'h0, 3'b000, 3'b000);
    @(posedge Clk);  // Third reset edge
    En <= 1'b1;
    for (int t = 0; t < NumTrans; t++) runTransaction();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule
